//--- source/lar_cast_pkg.sv
`default_nettype none

package lar_cast_pkg;

	// Vector width fixed by the register format
	localparam int LAR_WIDTH = 256;

	// Lane counts for each integer size
	localparam int LANES_8 = LAR_WIDTH / 8;
	localparam int LANES_16 = LAR_WIDTH / 16;
	localparam int LANES_32 = LAR_WIDTH / 32;
	localparam int LANES_64 = LAR_WIDTH / 64;

	typedef logic [LAR_WIDTH-1:0] lar_data_t;

	typedef logic [7:0] lane8_t;
	typedef logic [15:0] lane16_t;
	typedef logic [31:0] lane32_t;
	typedef logic [63:0] lane64_t;

	// Whole vector viewed as lanes of one size, lane 0 at the bottom
	typedef lane8_t [LANES_8-1:0] lanes8_t;
	typedef lane16_t [LANES_16-1:0] lanes16_t;
	typedef lane32_t [LANES_32-1:0] lanes32_t;
	typedef lane64_t [LANES_64-1:0] lanes64_t;

	// Larger code means wider lane
	typedef enum logic [1:0]
	{
		INT_SIZE_8 = 2'd0,
		INT_SIZE_16 = 2'd1,
		INT_SIZE_32 = 2'd2,
		INT_SIZE_64 = 2'd3
	} int_size_t;

	typedef struct packed
	{
		logic valid;
		logic is_signed;
		int_size_t src_size;
		int_size_t dst_size;
		lar_data_t data;
	} cast_req_t;

	typedef struct packed
	{
		logic valid;
		lar_data_t data;
	} cast_res_t;

endpackage

`default_nettype wire

//--- source/lane_widener.sv
`timescale 1ns/1ps
`default_nettype none

module lane_widener
	import lar_cast_pkg::*;
(
	input wire lar_data_t data,
	input wire int_size_t src_size,
	input wire int_size_t dst_size,
	input wire logic is_signed,
	output lar_data_t widened
);

	// Source vector sliced by each size that can be widened
	lanes8_t src8;
	lanes16_t src16;
	lanes32_t src32;

	// One candidate per source and destination pair
	lanes16_t w8_16;
	lanes32_t w8_32;
	lanes64_t w8_64;
	lanes32_t w16_32;
	lanes64_t w16_64;
	lanes64_t w32_64;

	assign src8 = data;
	assign src16 = data;
	assign src32 = data;

	// Only the low source lanes fit, one per destination lane
	for (genvar i = 0; i < LANES_16; i++)
	begin : g_w8_16
		assign w8_16[i] = {{8{is_signed & src8[i][7]}}, src8[i]};
	end

	for (genvar i = 0; i < LANES_32; i++)
	begin : g_w8_32
		assign w8_32[i] = {{24{is_signed & src8[i][7]}}, src8[i]};
	end

	for (genvar i = 0; i < LANES_64; i++)
	begin : g_w8_64
		assign w8_64[i] = {{56{is_signed & src8[i][7]}}, src8[i]};
	end

	for (genvar i = 0; i < LANES_32; i++)
	begin : g_w16_32
		assign w16_32[i] = {{16{is_signed & src16[i][15]}}, src16[i]};
	end

	for (genvar i = 0; i < LANES_64; i++)
	begin : g_w16_64
		assign w16_64[i] = {{48{is_signed & src16[i][15]}}, src16[i]};
	end

	for (genvar i = 0; i < LANES_64; i++)
	begin : g_w32_64
		assign w32_64[i] = {{32{is_signed & src32[i][31]}}, src32[i]};
	end

	// Pairs that are not a widening give zero
	always_comb
	begin
		widened = '0;
		case (dst_size)
		INT_SIZE_16:
		begin
			if (src_size == INT_SIZE_8)
				widened = w8_16;
		end

		INT_SIZE_32:
		begin
			case (src_size)
			INT_SIZE_8: widened = w8_32;
			INT_SIZE_16: widened = w16_32;
			default: widened = '0;
			endcase
		end

		INT_SIZE_64:
		begin
			case (src_size)
			INT_SIZE_8: widened = w8_64;
			INT_SIZE_16: widened = w16_64;
			INT_SIZE_32: widened = w32_64;
			default: widened = '0;
			endcase
		end

		default:
		begin
			widened = '0;
		end
		endcase
	end

endmodule

`default_nettype wire

//--- source/lane_narrower.sv
`timescale 1ns/1ps
`default_nettype none

module lane_narrower
	import lar_cast_pkg::*;
(
	input wire lar_data_t data,
	input wire int_size_t src_size,
	input wire int_size_t dst_size,
	output lar_data_t narrowed
);

	// Source vector sliced by each size that can be narrowed
	lanes16_t src16;
	lanes32_t src32;
	lanes64_t src64;

	// One candidate per source and destination pair
	lanes8_t n16_8;
	lanes8_t n32_8;
	lanes8_t n64_8;
	lanes16_t n32_16;
	lanes16_t n64_16;
	lanes32_t n64_32;

	assign src16 = data;
	assign src32 = data;
	assign src64 = data;

	// Lane i keeps the low bits of source lane i, upper lanes cleared
	for (genvar i = 0; i < LANES_8; i++)
	begin : g_to8
		if (i < LANES_16)
		begin : g_from16
			assign n16_8[i] = src16[i][7:0];
		end
		else
		begin : g_fill16
			assign n16_8[i] = '0;
		end

		if (i < LANES_32)
		begin : g_from32
			assign n32_8[i] = src32[i][7:0];
		end
		else
		begin : g_fill32
			assign n32_8[i] = '0;
		end

		if (i < LANES_64)
		begin : g_from64
			assign n64_8[i] = src64[i][7:0];
		end
		else
		begin : g_fill64
			assign n64_8[i] = '0;
		end
	end

	for (genvar i = 0; i < LANES_16; i++)
	begin : g_to16
		if (i < LANES_32)
		begin : g_from32
			assign n32_16[i] = src32[i][15:0];
		end
		else
		begin : g_fill32
			assign n32_16[i] = '0;
		end

		if (i < LANES_64)
		begin : g_from64
			assign n64_16[i] = src64[i][15:0];
		end
		else
		begin : g_fill64
			assign n64_16[i] = '0;
		end
	end

	for (genvar i = 0; i < LANES_32; i++)
	begin : g_to32
		if (i < LANES_64)
		begin : g_from64
			assign n64_32[i] = src64[i][31:0];
		end
		else
		begin : g_fill64
			assign n64_32[i] = '0;
		end
	end

	// Pairs that are not a narrowing give zero
	always_comb
	begin
		narrowed = '0;
		case (dst_size)
		INT_SIZE_8:
		begin
			case (src_size)
			INT_SIZE_16: narrowed = n16_8;
			INT_SIZE_32: narrowed = n32_8;
			INT_SIZE_64: narrowed = n64_8;
			default: narrowed = '0;
			endcase
		end

		INT_SIZE_16:
		begin
			case (src_size)
			INT_SIZE_32: narrowed = n32_16;
			INT_SIZE_64: narrowed = n64_16;
			default: narrowed = '0;
			endcase
		end

		INT_SIZE_32:
		begin
			if (src_size == INT_SIZE_64)
				narrowed = n64_32;
		end

		default:
		begin
			narrowed = '0;
		end
		endcase
	end

endmodule

`default_nettype wire

//--- source/cast_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cast_result_stage
	import lar_cast_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire cast_req_t req,
	input wire lar_data_t widened,
	input wire lar_data_t narrowed,
	output cast_res_t res
);

	logic same_size;
	logic is_widen;
	lar_data_t sel_data;
	cast_res_t res_q;

	// Enum order follows lane width
	assign same_size = (req.src_size == req.dst_size);
	assign is_widen = (req.src_size < req.dst_size);

	always_comb
	begin
		if (same_size)
		begin
			sel_data = req.data;
		end
		else if (is_widen)
		begin
			sel_data = widened;
		end
		else
		begin
			sel_data = narrowed;
		end
	end

	// Data holds its last value across idle cycles
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			res_q.valid <= 1'b0;
			res_q.data <= '0;
		end
		else
		begin
			res_q.valid <= req.valid;
			if (req.valid)
			begin
				res_q.data <= sel_data;
			end
		end
	end

	assign res = res_q;

	a_reset_idle: assert property (@(posedge clk) rst |=> !res.valid)
		else $error("result valid right after reset");

	// One result per request, exactly one cycle later
	a_valid_follows: assert property (@(posedge clk)
		!rst |=> (res.valid == $past(req.valid)))
		else $error("result valid does not follow request valid");

endmodule

`default_nettype wire

//--- source/int_vector_caster.sv
`timescale 1ns/1ps
`default_nettype none

module int_vector_caster
	import lar_cast_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire cast_req_t req,
	output cast_res_t res
);

	lar_data_t widened;
	lar_data_t narrowed;

	// Both converters run in parallel on every request
	lane_widener lane_widener_inst
	(
		.data(req.data),
		.src_size(req.src_size),
		.dst_size(req.dst_size),
		.is_signed(req.is_signed),
		.widened(widened)
	);

	lane_narrower lane_narrower_inst
	(
		.data(req.data),
		.src_size(req.src_size),
		.dst_size(req.dst_size),
		.narrowed(narrowed)
	);

	// Picks by size order and registers
	cast_result_stage cast_result_stage_inst
	(
		.clk(clk),
		.rst(rst),
		.req(req),
		.widened(widened),
		.narrowed(narrowed),
		.res(res)
	);

endmodule

`default_nettype wire

//--- test/cast_model.svh
`ifndef CAST_MODEL_SVH
`define CAST_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	logic feedback;
	feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
	return {state[14:0], feedback};
endfunction

// One LFSR step for each bit taken
function automatic lar_data_t random_bits(input int count);
	lar_data_t bits;
	int k;
	bits = '0;
	for (k = 0; k < count; k++)
	begin
		lfsr_state = lfsr_step(lfsr_state);
		bits[k] = lfsr_state[0];
	end
	return bits;
endfunction

function automatic cast_req_t random_request();
	cast_req_t r;
	lar_data_t bits;
	bits = random_bits(5);
	r.valid = 1'b1;
	r.is_signed = bits[0];
	r.src_size = int_size_t'(bits[2:1]);
	r.dst_size = int_size_t'(bits[4:3]);
	r.data = random_bits(LAR_WIDTH);
	return r;
endfunction

// Top bit of every lane of the given size
function automatic lar_data_t sign_mask(input int_size_t size);
	lar_data_t mask;
	int width;
	int k;
	width = 8 << int'(size);
	mask = '0;
	for (k = 0; k < LAR_WIDTH / width; k++)
		mask[k * width + width - 1] = 1'b1;
	return mask;
endfunction

// Lane i of the result comes from lane i of the source, for as many lanes as the wider size holds
function automatic cast_res_t cast_expect(input cast_req_t r);
	cast_res_t e;
	int src_w;
	int dst_w;
	int lanes;
	int i;
	int b;
	logic sign;
	src_w = 8 << int'(r.src_size);
	dst_w = 8 << int'(r.dst_size);
	e.valid = 1'b1;
	e.data = '0;
	if (src_w == dst_w)
	begin
		e.data = r.data;
	end
	else
	begin
		lanes = LAR_WIDTH / ((src_w > dst_w) ? src_w : dst_w);
		for (i = 0; i < lanes; i++)
		begin
			sign = r.is_signed & r.data[i * src_w + src_w - 1];
			for (b = 0; b < dst_w; b++)
			begin
				if (b < src_w)
					e.data[i * dst_w + b] = r.data[i * src_w + b];
				else
					e.data[i * dst_w + b] = sign;
			end
		end
	end
	return e;
endfunction

task automatic check_data(input lar_data_t got, input lar_data_t expected, input string what);
	if (got !== expected)
	begin
		mismatch_count++;
		$display("mismatch at %0t: %s, got %h expected %h", $time, what, got, expected);
	end
endtask

task automatic check_valid(input logic got, input logic expected, input string what);
	if (got !== expected)
	begin
		mismatch_count++;
		$display("mismatch at %0t: %s, got %b expected %b", $time, what, got, expected);
	end
endtask

`endif

//--- test/int_vector_caster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_vector_caster_tb
	import lar_cast_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int PAIR_REQS = 32;
	localparam int CORNER_REQS = 12;
	localparam int STREAM_REQS = 200;
	localparam int GAP_SLOTS = 120;
	localparam int RUN_CYCLES = RESET_CYCLES + 2 + PAIR_REQS + CORNER_REQS + STREAM_REQS
		+ GAP_SLOTS + 2;
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + 50;

	logic clk;
	logic rst;
	cast_req_t req;
	cast_res_t res;

	logic [15:0] lfsr_state = 16'd73;
	int mismatch_count = 0;
	int failure_count = 0;
	int cycle_count = 0;
	cast_res_t exp_q[$];
	lar_data_t last_data;

	`include "cast_model.svh"

	int_vector_caster int_vector_caster_inst
	(
		.clk(clk),
		.rst(rst),
		.req(req),
		.res(res)
	);

	always #5 clk = ~clk;

	task automatic send(input cast_req_t r);
		@(negedge clk);
		req = r;
		if (r.valid)
			exp_q.push_back(cast_expect(r));
	endtask

	initial
	begin
		cast_req_t r;
		lar_data_t bits;
		int s;
		int d;
		int g;
		int n;
		clk = 1'b0;
		rst = 1'b1;
		req = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_valid(res.valid, 1'b0, "valid on first edge after reset");
		check_data(res.data, '0, "data on first edge after reset");

		for (s = 0; s < 4; s++)
			for (d = 0; d < 4; d++)
				for (g = 0; g < 2; g++)
				begin
					r = random_request();
					r.is_signed = (g == 1);
					r.src_size = int_size_t'(s[1:0]);
					r.dst_size = int_size_t'(d[1:0]);
					send(r);
				end

		// Widening with every source lane negative
		for (s = 0; s < 3; s++)
			for (d = s + 1; d < 4; d++)
				for (g = 0; g < 2; g++)
				begin
					r = random_request();
					r.is_signed = (g == 1);
					r.src_size = int_size_t'(s[1:0]);
					r.dst_size = int_size_t'(d[1:0]);
					r.data = r.data | sign_mask(r.src_size);
					send(r);
				end

		for (n = 0; n < STREAM_REQS; n++)
			send(random_request());

		// About one slot in four left idle
		for (n = 0; n < GAP_SLOTS; n++)
		begin
			r = random_request();
			bits = random_bits(2);
			r.valid = (bits[1:0] != 2'b00);
			send(r);
		end

		r.valid = 1'b0;
		send(r);
		send(r);
		if (exp_q.size() != 0)
		begin
			failure_count++;
			$display("missing results: %0d requests never produced a result", exp_q.size());
		end
		$display("closing: %0d mismatches, %0d other errors", mismatch_count, failure_count);
		if (mismatch_count + failure_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Sampled just after the edge, once res has settled
	always
	begin
		cast_res_t expected;
		@(posedge clk);
		#1;
		if (rst)
		begin
			check_valid(res.valid, 1'b0, "valid during reset");
			check_data(res.data, '0, "data during reset");
			last_data = '0;
		end
		else
		begin
			check_valid(res.valid, req.valid, "valid one cycle after request");
			if (res.valid)
			begin
				if (exp_q.size() == 0)
				begin
					failure_count++;
					$display("error at %0t: unexpected result with no request outstanding", $time);
				end
				else
				begin
					expected = exp_q.pop_front();
					check_data(res.data, expected.data, "cast result");
					last_data = expected.data;
				end
			end
			else
			begin
				check_data(res.data, last_data, "data held while idle");
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
source/lar_cast_pkg.sv
source/lane_widener.sv
source/lane_narrower.sv
source/cast_result_stage.sv
source/int_vector_caster.sv
test/int_vector_caster_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the caster testbench with Verilator, pass decided from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
	--top-module int_vector_caster_tb -o int_vector_caster_sim > sim.log 2>&1 \
	&& ./obj_dir/int_vector_caster_sim >> sim.log 2>&1 \
	|| { echo "compile or run failed, see sim.log"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
